// File: logic/cdi_loader_pkg.sv
package cdi_loader_pkg;

    // ==============================
    // Bus widths
    // ==============================

    localparam int IOCTL_ADDR_W  = 25;
    localparam int IOCTL_INDEX_W = 16;
    localparam int SDRAM_ADDR_W  = 25;
    localparam int SDRAM_WORD_W  = 16;
    localparam int WORM_ADDR_W   = 13;
    localparam int WORM_BYTE_W   = 8;

    typedef logic [IOCTL_ADDR_W-1:0]  ioctl_addr_t;
    typedef logic [IOCTL_INDEX_W-1:0] ioctl_index_t;
    typedef logic [SDRAM_ADDR_W-1:0]  sdram_addr_t;
    typedef logic [SDRAM_WORD_W-1:0]  sdram_word_t;
    typedef logic [WORM_ADDR_W-1:0]   worm_addr_t;
    typedef logic [WORM_BYTE_W-1:0]   worm_byte_t;

    // ==============================
    // Download mapping
    // ==============================

    // Index bit 6 set means the file goes to the slave WORM
    localparam int WORM_INDEX_BIT = 6;

    // Boot ROM lives in the SDRAM window with prefix 001
    localparam logic [2:0] ROM_REGION = 3'b001;

    // Highest ioctl address bit kept for a ROM word
    localparam int ROM_WORD_MSB = 21;

    // Who drives the SDRAM while the core sits in reset
    typedef enum logic [1:0] {
        OWNER_ROM_DOWNLOAD,
        OWNER_REFRESH,
        OWNER_IDLE
    } owner_e;

endpackage

// File: logic/rom_load_if.sv
interface rom_load_if
    import cdi_loader_pkg::*;
();

    // One-cycle strobe for a decoded boot ROM word
    logic        word_valid;

    // Address already placed inside the ROM region
    sdram_addr_t word_addr;

    // Data already byte-swapped for the 68k
    sdram_word_t word_data;

    modport src (
        output word_valid,
        output word_addr,
        output word_data
    );

    modport dst (
        input word_valid,
        input word_addr,
        input word_data
    );

endinterface

// File: logic/ioctl_decode.sv
module ioctl_decode
    import cdi_loader_pkg::*;
(
    input  logic           clk_sys,
    input  logic           rst_n,

    input  logic           ioctl_wr,
    input  logic           ioctl_download,
    input  ioctl_addr_t    ioctl_addr,
    input  ioctl_index_t   ioctl_index,
    input  sdram_word_t    ioctl_dout,

    input  logic           status_reset,
    input  logic           button_reset,

    rom_load_if.src        rom,

    output logic           worm_word_valid,
    output worm_addr_t     worm_word_addr,
    output sdram_word_t    worm_word_data,

    output logic           core_reset
);

    logic        rom_wr;
    logic        worm_wr;
    sdram_addr_t rom_addr_mapped;
    sdram_word_t rom_data_swapped;

    // ==============================
    // Write classification
    // ==============================

    // boot0/boot1 come with bit 6 clear, the slave WORM image with it set
    assign rom_wr  = ioctl_wr && !ioctl_index[WORM_INDEX_BIT];
    assign worm_wr = ioctl_wr && ioctl_index[WORM_INDEX_BIT];

    // Word address into the ROM window, byte 0 of each word
    assign rom_addr_mapped = {ROM_REGION, ioctl_addr[ROM_WORD_MSB:1], 1'b0};

    // Host side is little endian, the 68k wants big endian
    assign rom_data_swapped = {ioctl_dout[7:0], ioctl_dout[15:8]};

    // ==============================
    // ROM word register
    // ==============================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rom.word_valid <= 1'b0;
        end else begin
            rom.word_valid <= rom_wr;
        end
    end

    // Held until the next ROM write replaces it
    always_ff @(posedge clk_sys) begin
        if (rom_wr) begin
            rom.word_addr <= rom_addr_mapped;
            rom.word_data <= rom_data_swapped;
        end
    end

    // WORM words go straight on, the byte writer registers them
    assign worm_word_valid = worm_wr;
    assign worm_word_addr  = ioctl_addr[WORM_ADDR_W-1:0];
    assign worm_word_data  = ioctl_dout;

    // ==============================
    // Core reset
    // ==============================

    // Console stays in reset for the whole download
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= status_reset || button_reset || ioctl_download;
        end
    end

endmodule

// File: logic/sdram_prep_arbiter.sv
module sdram_prep_arbiter
    import cdi_loader_pkg::*;
(
    input  logic         clk_sys,
    input  logic         rst_n,
    input  logic         core_reset,

    rom_load_if.dst      rom,

    // Request from the console core
    input  sdram_addr_t  core_addr,
    input  sdram_word_t  core_din,
    input  logic         core_rd,
    input  logic         core_wr,
    input  logic         core_word,
    input  logic         core_burst,
    input  logic         core_refresh,

    // Request towards the SDRAM controller
    input  logic         sdram_busy,
    output sdram_addr_t  sdram_addr,
    output sdram_word_t  sdram_din,
    output logic         sdram_rd,
    output logic         sdram_wr,
    output logic         sdram_word,
    output logic         sdram_burst,
    output logic         sdram_refresh,

    output logic         rom_overflow
);

    logic        pending;
    sdram_addr_t pend_addr;
    sdram_word_t pend_data;
    logic        busy_q;
    owner_e      owner;
    owner_e      owner_q;
    owner_e      owner_next;
    logic        write_done;
    logic        word_ready;
    logic        prep_rd;
    logic        prep_wr;
    logic        prep_refresh;

    // Busy just fell at the end of a download write
    assign write_done = (owner_q == OWNER_ROM_DOWNLOAD) && busy_q && !sdram_busy;

    // Keeps the finished word from being issued a second time
    assign word_ready = pending && !write_done;

    // ==============================
    // Owner selection
    // ==============================

    always_comb begin
        owner_next = OWNER_IDLE;
        if (core_reset) begin
            owner_next = word_ready ? OWNER_ROM_DOWNLOAD : OWNER_REFRESH;
        end

        // Owner stays put for the length of an access
        owner = sdram_busy ? owner_q : owner_next;
    end

    always_comb begin
        prep_rd      = 1'b0;
        prep_wr      = 1'b0;
        prep_refresh = 1'b0;

        case (owner)
            OWNER_ROM_DOWNLOAD: begin
                prep_wr = 1'b1;
            end
            OWNER_REFRESH: begin
                prep_rd      = 1'b1;
                prep_refresh = 1'b1;
            end
            default: begin
            end
        endcase

        if (sdram_busy) begin
            prep_rd = 1'b0;
            prep_wr = 1'b0;
        end
    end

    // ==============================
    // Pending word and overflow
    // ==============================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pending      <= 1'b0;
            busy_q       <= 1'b0;
            owner_q      <= OWNER_IDLE;
            rom_overflow <= 1'b0;
        end else begin
            busy_q  <= sdram_busy;
            owner_q <= owner;

            // A new word wins over the clear of the previous one
            if (rom.word_valid) begin
                pending <= 1'b1;
            end else if (write_done) begin
                pending <= 1'b0;
            end

            // Sticky until the next rst_n
            if (rom.word_valid && word_ready) begin
                rom_overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rom.word_valid) begin
            pend_addr <= rom.word_addr;
            pend_data <= rom.word_data;
        end
    end

    // ==============================
    // Controller request mux
    // ==============================

    // Preparation uses plain word accesses only
    assign sdram_addr    = core_reset ? pend_addr    : core_addr;
    assign sdram_din     = core_reset ? pend_data    : core_din;
    assign sdram_rd      = core_reset ? prep_rd      : core_rd;
    assign sdram_wr      = core_reset ? prep_wr      : core_wr;
    assign sdram_word    = core_reset ? 1'b1         : core_word;
    assign sdram_burst   = core_reset ? 1'b0         : core_burst;
    assign sdram_refresh = core_reset ? prep_refresh : core_refresh;

endmodule

// File: logic/worm_byte_writer.sv
module worm_byte_writer
    import cdi_loader_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,

    input  logic        worm_word_valid,
    input  worm_addr_t  worm_word_addr,
    input  sdram_word_t worm_word_data,

    output logic        worm_wr,
    output worm_addr_t  worm_addr,
    output worm_byte_t  worm_data
);

    logic       word_valid_q;
    worm_byte_t upper_byte;

    // ==============================
    // Write strobe
    // ==============================

    // High on both cycles after a word, one per byte
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            word_valid_q <= 1'b0;
            worm_wr      <= 1'b0;
        end else begin
            word_valid_q <= worm_word_valid;
            worm_wr      <= worm_word_valid || word_valid_q;
        end
    end

    // ==============================
    // Byte data and address
    // ==============================

    always_ff @(posedge clk_sys) begin
        if (worm_word_valid) begin
            // Low byte first, the high byte waits one cycle
            worm_addr  <= worm_word_addr;
            worm_data  <= worm_word_data[7:0];
            upper_byte <= worm_word_data[15:8];
        end else begin
            worm_data    <= upper_byte;
            worm_addr[0] <= 1'b1;
        end
    end

endmodule

// File: logic/cdi_loader_top.sv
module cdi_loader_top
    import cdi_loader_pkg::*;
(
    input  logic         clk_sys,
    input  logic         rst_n,

    // Download port
    input  logic         ioctl_wr,
    input  logic         ioctl_download,
    input  ioctl_addr_t  ioctl_addr,
    input  ioctl_index_t ioctl_index,
    input  sdram_word_t  ioctl_dout,

    // Reset sources
    input  logic         status_reset,
    input  logic         button_reset,
    output logic         core_reset,

    // Console core request
    input  sdram_addr_t  core_addr,
    input  sdram_word_t  core_din,
    input  logic         core_rd,
    input  logic         core_wr,
    input  logic         core_word,
    input  logic         core_burst,
    input  logic         core_refresh,

    // SDRAM controller
    input  logic         sdram_busy,
    output sdram_addr_t  sdram_addr,
    output sdram_word_t  sdram_din,
    output logic         sdram_rd,
    output logic         sdram_wr,
    output logic         sdram_word,
    output logic         sdram_burst,
    output logic         sdram_refresh,
    output logic         rom_overflow,

    // Slave WORM
    output logic         worm_wr,
    output worm_addr_t   worm_addr,
    output worm_byte_t   worm_data
);

    logic        worm_word_valid;
    worm_addr_t  worm_word_addr;
    sdram_word_t worm_word_data;

    rom_load_if rom_load ();

    ioctl_decode u_decode (
        .clk_sys,
        .rst_n,
        .ioctl_wr,
        .ioctl_download,
        .ioctl_addr,
        .ioctl_index,
        .ioctl_dout,
        .status_reset,
        .button_reset,
        .rom             (rom_load.src),
        .worm_word_valid,
        .worm_word_addr,
        .worm_word_data,
        .core_reset
    );

    sdram_prep_arbiter u_arbiter (
        .clk_sys,
        .rst_n,
        .core_reset,
        .rom           (rom_load.dst),
        .core_addr,
        .core_din,
        .core_rd,
        .core_wr,
        .core_word,
        .core_burst,
        .core_refresh,
        .sdram_busy,
        .sdram_addr,
        .sdram_din,
        .sdram_rd,
        .sdram_wr,
        .sdram_word,
        .sdram_burst,
        .sdram_refresh,
        .rom_overflow
    );

    worm_byte_writer u_worm (
        .clk_sys,
        .rst_n,
        .worm_word_valid,
        .worm_word_addr,
        .worm_word_data,
        .worm_wr,
        .worm_addr,
        .worm_data
    );

endmodule

// File: sim/cdi_loader_assertions.sv
module cdi_loader_assertions (
    input logic clk_sys,
    input logic rst_n,
    input logic core_reset,
    input logic sdram_busy,
    input logic sdram_rd,
    input logic sdram_wr,
    input logic sdram_refresh,
    input logic rom_overflow
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned failures = 0;

    // ==============================
    // Preparer request rules
    // ==============================

    // Controller gets no new preparer access while it is busy
    no_request_while_busy: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (core_reset && sdram_busy) |-> !(sdram_rd || sdram_wr)
    ) else begin
        $error("sdram_rd or sdram_wr raised while the controller is busy");
        failures++;
    end

    // A write cycle is never also a refresh
    no_write_with_refresh: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !(sdram_wr && sdram_refresh)
    ) else begin
        $error("sdram_wr and sdram_refresh high in the same cycle");
        failures++;
    end

    // Overflow flag only clears through rst_n
    overflow_is_sticky: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !$fell(rom_overflow)
    ) else begin
        $error("rom_overflow fell while rst_n was high");
        failures++;
    end

endmodule

bind sdram_prep_arbiter cdi_loader_assertions u_arbiter_checks (.*);

// File: sim/cdi_loader_tb.sv
module cdi_loader_tb
    import cdi_loader_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_RECORDS = 64;
    localparam int WAIT_LIMIT  = 64;

    typedef logic [8*32-1:0] name_t;

    logic         clk_sys;
    logic         rst_n;
    logic         ioctl_wr;
    logic         ioctl_download;
    ioctl_addr_t  ioctl_addr;
    ioctl_index_t ioctl_index;
    sdram_word_t  ioctl_dout;
    logic         status_reset;
    logic         button_reset;
    logic         core_reset;
    sdram_addr_t  core_addr;
    sdram_word_t  core_din;
    logic         core_rd, core_wr, core_word, core_burst, core_refresh;
    logic         sdram_busy = 1'b0;
    sdram_addr_t  sdram_addr;
    sdram_word_t  sdram_din;
    logic         sdram_rd, sdram_wr, sdram_word, sdram_burst, sdram_refresh;
    logic         rom_overflow;
    logic         worm_wr;
    worm_addr_t   worm_addr;
    worm_byte_t   worm_data;

    integer       seed = 32'h68b9_eae3;
    int           busy_left;

    name_t        rec_name [MAX_RECORDS];
    name_t        rec_kind [MAX_RECORDS];
    logic [31:0]  rec_p    [MAX_RECORDS][5];
    int           rec_count = 0;
    logic         tests_loaded = 1'b0;

    cdi_loader_top i_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // ==============================
    // SDRAM controller busy model
    // ==============================

    // Busy rises the cycle after a request and stays up for 2 to 5 cycles
    always @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sdram_busy <= 1'b0;
            busy_left  <= 0;
        end else if (sdram_busy) begin
            busy_left <= busy_left - 1;
            if (busy_left == 1) begin
                sdram_busy <= 1'b0;
            end
        end else if (sdram_rd || sdram_wr) begin
            sdram_busy <= 1'b1;
            busy_left  <= 2 + ($unsigned($random(seed)) % 4);
        end
    end

    // ==============================
    // Checks
    // ==============================

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic check_addr(input name_t name, input sdram_addr_t exp, input sdram_addr_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Mismatch in %0s: sdram_addr expected %h, got %h",
                name, exp, act));
        end
    endtask

    task automatic check_word(input name_t name, input sdram_word_t exp, input sdram_word_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Mismatch in %0s: sdram_din expected %h, got %h",
                name, exp, act));
        end
    endtask

    task automatic check_worm(input name_t name, input worm_addr_t exp_addr,
                              input worm_byte_t exp_data, input worm_addr_t act_addr,
                              input worm_byte_t act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            stop_with_failure($sformatf("Mismatch in %0s: worm write expected %h/%h, got %h/%h",
                name, exp_addr, exp_data, act_addr, act_data));
        end
    endtask

    task automatic check_bit(input name_t name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Mismatch in %0s: %s expected %b, got %b",
                name, what, exp, act));
        end
    endtask

    // ==============================
    // Stimulus helpers
    // ==============================

    task automatic load_tests();
        int               fd;
        int               code;
        logic [8*160-1:0] line;
        name_t            name;
        name_t            kind;
        logic [31:0]      p0, p1, p2, p3, p4;
        fd = $fopen("sim/cdi_loader_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the test file sim/cdi_loader_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                code = $sscanf(line, "%s %s %h %h %h %h %h", name, kind, p0, p1, p2, p3, p4);
                // Lines starting with # describe the columns
                if (code == 7 && name != "#" && rec_count < MAX_RECORDS) begin
                    rec_name[rec_count] = name;
                    rec_kind[rec_count] = kind;
                    rec_p[rec_count]    = '{p0, p1, p2, p3, p4};
                    rec_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Download level decides whether the preparer or the core owns the SDRAM
    task automatic set_download(input logic active);
        int n;
        n = 0;
        @(posedge clk_sys);
        status_reset   <= 1'b0;
        button_reset   <= 1'b0;
        ioctl_download <= active;
        @(negedge clk_sys);
        while (core_reset !== active) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure("core_reset did not follow the download level");
            end
            n++;
            @(negedge clk_sys);
        end
    endtask

    task automatic send_word(input ioctl_index_t idx, input ioctl_addr_t addr,
                             input sdram_word_t data);
        @(posedge clk_sys);
        ioctl_index <= idx;
        ioctl_addr  <= addr;
        ioctl_dout  <= data;
        ioctl_wr    <= 1'b1;
        @(posedge clk_sys);
        ioctl_wr    <= 1'b0;
    endtask

    // Returns once busy is low and the preparer is back on refresh reads
    task automatic wait_refresh_idle(input name_t name, input logic no_write);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (sdram_busy || !sdram_rd) begin
            if (no_write && sdram_wr) begin
                stop_with_failure($sformatf("%0s: a second SDRAM write for one ROM word", name));
            end
            if (n == WAIT_LIMIT) begin
                stop_with_failure($sformatf("%0s: the preparer never went back to refresh",
                    name));
            end
            n++;
            @(negedge clk_sys);
        end
    endtask

    // ==============================
    // Test kinds
    // ==============================

    task automatic run_rom(input int i);
        int n;
        n = 0;
        set_download(1'b1);
        send_word(ioctl_index_t'(rec_p[i][4]), ioctl_addr_t'(rec_p[i][0]),
            sdram_word_t'(rec_p[i][1]));
        @(negedge clk_sys);
        while (!sdram_wr) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure($sformatf("%0s: the ROM word was never written", rec_name[i]));
            end
            n++;
            @(negedge clk_sys);
        end
        check_addr(rec_name[i], sdram_addr_t'(rec_p[i][2]), sdram_addr);
        check_word(rec_name[i], sdram_word_t'(rec_p[i][3]), sdram_din);
        wait_refresh_idle(rec_name[i], 1'b1);
        check_bit(rec_name[i], "sdram_wr", 1'b0, sdram_wr);
        check_bit(rec_name[i], "sdram_refresh", 1'b1, sdram_refresh);
        check_bit(rec_name[i], "sdram_word", 1'b1, sdram_word);
        check_bit(rec_name[i], "sdram_burst", 1'b0, sdram_burst);
    endtask

    task automatic run_worm(input int i);
        set_download(1'b1);
        send_word(16'h0041, ioctl_addr_t'(rec_p[i][0]), sdram_word_t'(rec_p[i][1]));
        @(negedge clk_sys);
        check_bit(rec_name[i], "worm_wr", 1'b1, worm_wr);
        check_worm(rec_name[i], worm_addr_t'(rec_p[i][2]), rec_p[i][4][7:0], worm_addr, worm_data);
        @(negedge clk_sys);
        check_bit(rec_name[i], "worm_wr", 1'b1, worm_wr);
        check_worm(rec_name[i], worm_addr_t'(rec_p[i][3]), rec_p[i][4][15:8], worm_addr, worm_data);
        @(negedge clk_sys);
        check_bit(rec_name[i], "worm_wr", 1'b0, worm_wr);
    endtask

    task automatic run_core(input int i);
        set_download(1'b0);
        @(posedge clk_sys);
        core_addr <= sdram_addr_t'(rec_p[i][0]);
        core_din  <= sdram_word_t'(rec_p[i][1]);
        {core_refresh, core_burst, core_word, core_wr, core_rd} <= rec_p[i][2][4:0];
        @(negedge clk_sys);
        check_addr(rec_name[i], sdram_addr_t'(rec_p[i][0]), sdram_addr);
        check_word(rec_name[i], sdram_word_t'(rec_p[i][1]), sdram_din);
        check_bit(rec_name[i], "sdram_rd", rec_p[i][3][0], sdram_rd);
        check_bit(rec_name[i], "sdram_wr", rec_p[i][3][1], sdram_wr);
        check_bit(rec_name[i], "sdram_word", rec_p[i][3][2], sdram_word);
        check_bit(rec_name[i], "sdram_burst", rec_p[i][3][3], sdram_burst);
        check_bit(rec_name[i], "sdram_refresh", rec_p[i][3][4], sdram_refresh);
        @(posedge clk_sys);
        {core_refresh, core_burst, core_word, core_wr, core_rd} <= 5'b0;
    endtask

    task automatic run_reset(input int i);
        @(posedge clk_sys);
        {status_reset, button_reset, ioctl_download} <= rec_p[i][0][2:0];
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit(rec_name[i], "core_reset", rec_p[i][1][0], core_reset);
    endtask

    // Two ROM words back to back, the second lands while the first is pending
    task automatic run_overflow(input int i);
        set_download(1'b1);
        send_word(16'h0000, ioctl_addr_t'(rec_p[i][0]), sdram_word_t'(rec_p[i][1]));
        ioctl_addr <= ioctl_addr_t'(rec_p[i][2]);
        ioctl_dout <= sdram_word_t'(rec_p[i][3]);
        ioctl_wr   <= 1'b1;
        @(posedge clk_sys);
        ioctl_wr   <= 1'b0;
        @(posedge clk_sys);
        wait_refresh_idle(rec_name[i], 1'b0);
        check_bit(rec_name[i], "rom_overflow", rec_p[i][4][0], rom_overflow);
        @(posedge sdram_busy);
        wait_refresh_idle(rec_name[i], 1'b1);
        check_bit(rec_name[i], "rom_overflow", rec_p[i][4][0], rom_overflow);
    endtask

    // ==============================
    // Main sequence and watchdog
    // ==============================

    initial begin
        rst_n          = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_download = 1'b0;
        ioctl_addr     = '0;
        ioctl_index    = '0;
        ioctl_dout     = '0;
        status_reset   = 1'b0;
        button_reset   = 1'b0;
        core_addr      = '0;
        core_din       = '0;
        {core_refresh, core_burst, core_word, core_wr, core_rd} = 5'b0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (4) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        check_bit("reset_values", "core_reset", 1'b1, core_reset);
        check_bit("reset_values", "worm_wr", 1'b0, worm_wr);
        check_bit("reset_values", "sdram_wr", 1'b0, sdram_wr);
        check_bit("reset_values", "rom_overflow", 1'b0, rom_overflow);
        for (int i = 0; i < rec_count; i++) begin
            case (rec_kind[i])
                "rom":      run_rom(i);
                "worm":     run_worm(i);
                "core":     run_core(i);
                "reset":    run_reset(i);
                "overflow": run_overflow(i);
                default:    stop_with_failure($sformatf("Unknown test kind in record %0d", i));
            endcase
        end
        repeat (2) @(posedge clk_sys);
        if (rec_count > 0 && i_dut.u_arbiter.u_arbiter_checks.failures == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("No records were run, or an arbiter assertion failed");
        end
    end

    initial begin
        wait (i_dut.u_arbiter.u_arbiter_checks.failures != 0);
        stop_with_failure("An arbiter assertion failed during the run");
    end

    initial begin
        wait (tests_loaded);
        repeat (rec_count * 200 + 20) @(posedge clk_sys);
        stop_with_failure("Timeout: the tests did not finish in the expected time");
    end

endmodule

// File: sim/cdi_loader_tests.txt
# name kind p0 p1 p2 p3 p4, all p fields in hex
# rom: ioctl_addr dout exp_sdram_addr exp_sdram_din ioctl_index
# worm: ioctl_addr dout exp_low_addr exp_high_addr exp_bytes(high,low)
# core: core_addr core_din ctrl exp_ctrl unused, ctrl bits refresh burst word wr rd
# reset: sources(status button download) exp_core_reset unused unused unused
# overflow: addr1 dout1 addr2 dout2 exp_overflow
rom_first          rom      0000000 1234 0400000 3412 0000
rom_second         rom      0000002 beef 0400002 efbe 0000
rom_mid            rom      0001234 00ff 0401234 ff00 0001
rom_odd_addr       rom      0123457 a55a 0523456 5aa5 0001
rom_top            rom      03ffffe 8001 07ffffe 0180 0080
rom_high_bits      rom      1c00010 c3d2 0400010 d2c3 0000
worm_even          worm     0010 3412 0010 0011 3412
worm_top           worm     1ffe cafe 1ffe 1fff cafe
worm_odd           worm     2345 9a01 0345 0345 9a01
worm_page          worm     0a20 7755 0a20 0a21 7755
reset_none         reset    0 0 0 0 0
reset_status       reset    4 1 0 0 0
reset_button       reset    2 1 0 0 0
reset_download     reset    1 1 0 0 0
reset_all          reset    7 1 0 0 0
reset_clear        reset    0 0 0 0 0
core_read          core     0123456 dead 05 05 0
core_write         core     1abcdef 5a5a 0e 0e 0
core_refresh       core     0000000 0000 11 11 0
core_byte          core     0fffffe ffff 01 01 0
rom_after_core     rom      0000100 0102 0400100 0201 0000
overflow_pair      overflow 0000200 1111 0000202 2222 1
rom_after_overflow rom      0000204 3344 0400204 4433 0000
reset_final        reset    0 0 0 0 0

// File: list.f
logic/cdi_loader_pkg.sv
logic/rom_load_if.sv
logic/ioctl_decode.sv
logic/sdram_prep_arbiter.sv
logic/worm_byte_writer.sv
logic/cdi_loader_top.sv
sim/cdi_loader_assertions.sv
sim/cdi_loader_tb.sv

// File: Bender.yml
package:
  name: cdi_loader

sources:
  - files:
      - logic/cdi_loader_pkg.sv
      - logic/rom_load_if.sv
      - logic/ioctl_decode.sv
      - logic/sdram_prep_arbiter.sv
      - logic/worm_byte_writer.sv
      - logic/cdi_loader_top.sv
  - target: simulation
    files:
      - sim/cdi_loader_assertions.sv
      - sim/cdi_loader_tb.sv
